// File: build.f
logic/lc_sync_pkg.sv
logic/lc_flop_2sync.sv
logic/lc_sync.sv
logic/lc_tx_monitor.sv
logic/lc_sync_cfg.sv
logic/lc_sync_top.sv
test/lc_sync_sva.sv
test/tb_lc_sync_top.sv

// File: test/tb_lc_sync_top.sv
// Testbench for lc_sync_top with random enables plus mask and clear scenarios
// Every negedge compares the DUT with a pipeline and sticky status model
`timescale 1ns/1ps
`default_nettype none

module tb_lc_sync_top;

  localparam int NumCopies = 2;
  localparam lc_sync_pkg::lc_bundle_t ResetBundle = '{
    dft_en: lc_sync_pkg::Off, hw_debug_en: lc_sync_pkg::Off, escalate_en: lc_sync_pkg::On};
  localparam lc_sync_pkg::lc_bundle_t IdleBundle = '{
    dft_en: lc_sync_pkg::Off, hw_debug_en: lc_sync_pkg::Off, escalate_en: lc_sync_pkg::Off};

  // Starts low so time zero carries no clock edge
  logic                                    clk_i = 1'b0;
  logic                                    rst_ni;
  lc_sync_pkg::lc_bundle_t                 lc_bundle_i;
  logic                                    cfg_mask_we_i;
  lc_sync_pkg::lc_flags_t                  cfg_mask_i;
  logic                                    status_clr_i;
  lc_sync_pkg::lc_bundle_t [NumCopies-1:0] lc_copies_o;
  lc_sync_pkg::lc_flags_t                  status_o;
  logic                                    alarm_o;

  int unsigned errors;
  int unsigned checks;
  int unsigned timeouts;
  logic [31:0] rng_state;

  // Input as seen one, two and three edges after sampling
  lc_sync_pkg::lc_bundle_t hist1;
  lc_sync_pkg::lc_bundle_t hist2;
  lc_sync_pkg::lc_bundle_t hist3;
  logic [2:0] exp_status;
  logic [2:0] exp_mask;
  logic       exp_alarm;

  lc_sync_top #(.NumCopies(NumCopies), .AsyncOn(1'b1)) u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lc_bundle_i  (lc_bundle_i),
    .cfg_mask_we_i(cfg_mask_we_i),
    .cfg_mask_i   (cfg_mask_i),
    .status_clr_i (status_clr_i),
    .lc_copies_o  (lc_copies_o),
    .status_o     (status_o),
    .alarm_o      (alarm_o)
  );

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Only the two named encodings are legal
  function automatic logic legal_enc(lc_sync_pkg::lc_tx_t v);
    return (v == lc_sync_pkg::On) || (v == lc_sync_pkg::Off);
  endfunction

  function automatic logic [2:0] bad_fields(lc_sync_pkg::lc_bundle_t b);
    return {!legal_enc(b.dft_en), !legal_enc(b.hw_debug_en), !legal_enc(b.escalate_en)};
  endfunction

  // One in four draws gives an illegal pattern
  function automatic lc_sync_pkg::lc_tx_t pick_enc(logic [7:0] r);
    logic [3:0] v;
    if (r[1:0] == 2'b00) begin
      v = r[7:4];
      if (legal_enc(lc_sync_pkg::lc_tx_t'(v))) begin
        v = 4'b0000;
      end
    end else begin
      v = r[2] ? lc_sync_pkg::On : lc_sync_pkg::Off;
    end
    return lc_sync_pkg::lc_tx_t'(v);
  endfunction

  task automatic expect_bits(logic [2:0] got, logic [2:0] want, string what);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic hold_bundle(lc_sync_pkg::lc_bundle_t b, int cycles);
    @(posedge clk_i);
    lc_bundle_i <= b;
    repeat (cycles - 1) @(posedge clk_i);
  endtask

  task automatic write_mask(logic [2:0] m);
    @(posedge clk_i);
    cfg_mask_we_i <= 1'b1;
    cfg_mask_i    <= m;
    @(posedge clk_i);
    cfg_mask_we_i <= 1'b0;
  endtask

  // Drain the pipeline with legal values, then clear status
  task automatic flush_and_clear();
    hold_bundle(IdleBundle, 4);
    @(posedge clk_i);
    status_clr_i <= 1'b1;
    @(posedge clk_i);
    status_clr_i <= 1'b0;
    @(negedge clk_i);
    expect_bits(status_o, 3'b000, "status after clear");
    expect_bits({2'b00, alarm_o}, 3'b000, "alarm after clear");
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model and per-cycle checks
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist1      <= ResetBundle;
      hist2      <= ResetBundle;
      hist3      <= ResetBundle;
      exp_status <= '0;
      exp_mask   <= '1;
    end else begin
      hist1      <= lc_bundle_i;
      hist2      <= hist1;
      hist3      <= hist2;
      // New invalid flag wins over a clear
      exp_status <= (exp_status & ~{3{status_clr_i}}) | bad_fields(hist3);
      if (cfg_mask_we_i) begin
        exp_mask <= cfg_mask_i;
      end
    end
  end

  assign exp_alarm = |(exp_status & exp_mask);

  always @(negedge clk_i) begin
    for (int j = 0; j < NumCopies; j++) begin
      checks++;
      assert (lc_copies_o[j] == hist2) else begin
        errors++;
        $display("mismatch at %0t: copy %0d is %h, expected %h", $time, j, lc_copies_o[j], hist2);
      end
    end
    expect_bits(status_o, exp_status, "status");
    expect_bits({2'b00, alarm_o}, {2'b00, exp_alarm}, "alarm");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int wait_count;
    logic [31:0] r;
    lc_sync_pkg::lc_bundle_t stim;
    errors        = 0;
    checks        = 0;
    timeouts      = 0;
    rng_state     = 32'd44;
    rst_ni        = 1'b0;
    lc_bundle_i   = ResetBundle;
    cfg_mask_we_i = 1'b0;
    cfg_mask_i    = '1;
    status_clr_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Random enables, each held six cycles, with an occasional clear
    for (int i = 0; i < 40; i++) begin
      rng_state        = xorshift32(rng_state);
      r                = rng_state;
      stim.dft_en      = pick_enc(r[7:0]);
      stim.hw_debug_en = pick_enc(r[15:8]);
      stim.escalate_en = pick_enc(r[23:16]);
      @(posedge clk_i);
      lc_bundle_i  <= stim;
      status_clr_i <= (r[26:24] == 3'b000);
      @(posedge clk_i);
      status_clr_i <= 1'b0;
      repeat (4) @(posedge clk_i);
    end
    flush_and_clear();

    // Masked field still sets status but keeps the alarm low
    write_mask(3'b011);
    stim = IdleBundle;
    stim.dft_en = lc_sync_pkg::lc_tx_t'(4'b1111);
    hold_bundle(stim, 1);
    wait_count = 0;
    do begin
      @(negedge clk_i);
      wait_count++;
    end while (!status_o.dft_en && wait_count < 20);
    if (!status_o.dft_en) begin
      timeouts++;
      $display("timeout: dft_en status never set with the field masked");
    end
    expect_bits({2'b00, alarm_o}, 3'b000, "alarm while masked");
    hold_bundle(IdleBundle, 1);
    write_mask(3'b111);
    @(negedge clk_i);
    expect_bits({2'b00, alarm_o}, 3'b001, "alarm after unmask");

    // One-cycle invalid pulse lands on the same edge as a clear
    stim = IdleBundle;
    stim.hw_debug_en = lc_sync_pkg::lc_tx_t'(4'b0110);
    hold_bundle(stim, 1);
    hold_bundle(IdleBundle, 1);
    wait_count = 0;
    do begin
      @(negedge clk_i);
      wait_count++;
    end while (legal_enc(hist2.hw_debug_en) && wait_count < 20);
    if (legal_enc(hist2.hw_debug_en)) begin
      timeouts++;
      $display("timeout: invalid debug value never reached the synchronized copies");
    end
    @(posedge clk_i);
    status_clr_i <= 1'b1;
    @(posedge clk_i);
    status_clr_i <= 1'b0;
    @(negedge clk_i);
    expect_bits(status_o, 3'b010, "status after clear with new flag");

    // Plain clear drops status and alarm
    flush_and_clear();

    repeat (4) @(posedge clk_i);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/lc_sync_sva.sv
// Concurrent checks on the sync block outputs, bound into lc_sync_top
// Compiled only with the testbench
`timescale 1ns/1ps
`default_nettype none

module lc_sync_sva #(
  parameter int NumCopies = 2
) (
  input wire                                          clk_i,
  input wire                                          rst_ni,
  input wire                                          cfg_mask_we_i,
  input wire lc_sync_pkg::lc_flags_t                  cfg_mask_i,
  input wire lc_sync_pkg::lc_bundle_t [NumCopies-1:0] lc_copies_i,
  input wire lc_sync_pkg::lc_flags_t                  status_i,
  input wire                                          alarm_i
);

  // Shadow of the alarm mask, follows the write strobe
  logic [lc_sync_pkg::NumSig-1:0] mask_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '1;
    end else if (cfg_mask_we_i) begin
      mask_q <= cfg_mask_i;
    end
  end

  // No X or Z on anything the consumers see
  outputs_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({lc_copies_i, status_i, alarm_i}))
    else $error("copies, status or alarm went unknown");

  // Every copy carries the same value
  for (genvar j = 1; j < NumCopies; j++) begin : gen_copy_eq
    copies_equal_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      lc_copies_i[j] == lc_copies_i[0])
      else $error("copy %0d differs from copy 0", j);
  end

  // Alarm is the masked OR of status
  alarm_matches_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alarm_i == |(status_i & mask_q))
    else $error("alarm does not match the masked status");

endmodule

bind lc_sync_top lc_sync_sva #(.NumCopies(NumCopies)) u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .cfg_mask_we_i(cfg_mask_we_i),
  .cfg_mask_i   (cfg_mask_i),
  .lc_copies_i  (lc_copies_o),
  .status_i     (status_o),
  .alarm_i      (alarm_o)
);

`default_nettype wire

// File: logic/lc_sync_top.sv
// Top of the life cycle signal distribution block
// Syncs each enable, checks encodings and reports alarms
`timescale 1ns/1ps
`default_nettype none

module lc_sync_top #(
  parameter int NumCopies = 2,
  parameter bit AsyncOn   = 1
) (
  input  wire                                     clk_i,
  input  wire                                     rst_ni,
  input  lc_sync_pkg::lc_bundle_t                 lc_bundle_i,
  input  wire                                     cfg_mask_we_i,
  input  lc_sync_pkg::lc_flags_t                  cfg_mask_i,
  input  wire                                     status_clr_i,
  output lc_sync_pkg::lc_bundle_t [NumCopies-1:0] lc_copies_o,
  output lc_sync_pkg::lc_flags_t                  status_o,
  output logic                                    alarm_o
);

  // Per-signal copies straight from the synchronizers
  lc_sync_pkg::lc_tx_t [NumCopies-1:0] dft_copies;
  lc_sync_pkg::lc_tx_t [NumCopies-1:0] debug_copies;
  lc_sync_pkg::lc_tx_t [NumCopies-1:0] esc_copies;

  // Copy 0 of each enable, watched by the monitor
  lc_sync_pkg::lc_bundle_t sync_bundle;
  lc_sync_pkg::lc_flags_t  invalid_q;

  ////////////////////////////////////////////////////////////
  // Synchronizers
  ////////////////////////////////////////////////////////////

  lc_sync #(.NumCopies(NumCopies), .AsyncOn(AsyncOn), .ResetValueIsOn(1'b0)) u_sync_dft (
    .clk_i(clk_i), .rst_ni(rst_ni), .lc_en_i(lc_bundle_i.dft_en), .lc_en_o(dft_copies)
  );

  lc_sync #(.NumCopies(NumCopies), .AsyncOn(AsyncOn), .ResetValueIsOn(1'b0)) u_sync_debug (
    .clk_i(clk_i), .rst_ni(rst_ni), .lc_en_i(lc_bundle_i.hw_debug_en), .lc_en_o(debug_copies)
  );

  // Escalation resets to On
  lc_sync #(.NumCopies(NumCopies), .AsyncOn(AsyncOn), .ResetValueIsOn(1'b1)) u_sync_esc (
    .clk_i(clk_i), .rst_ni(rst_ni), .lc_en_i(lc_bundle_i.escalate_en), .lc_en_o(esc_copies)
  );

  // Regroup per consumer
  for (genvar j = 0; j < NumCopies; j++) begin : gen_bundle
    assign lc_copies_o[j].dft_en      = dft_copies[j];
    assign lc_copies_o[j].hw_debug_en = debug_copies[j];
    assign lc_copies_o[j].escalate_en = esc_copies[j];
  end

  assign sync_bundle = lc_copies_o[0];

  ////////////////////////////////////////////////////////////
  // Monitor and configuration
  ////////////////////////////////////////////////////////////

  lc_tx_monitor u_monitor (
    .clk_i(clk_i), .rst_ni(rst_ni), .sync_bundle_i(sync_bundle), .invalid_o(invalid_q)
  );

  lc_sync_cfg u_cfg (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_mask_we_i(cfg_mask_we_i),
    .cfg_mask_i   (cfg_mask_i),
    .status_clr_i (status_clr_i),
    .invalid_i    (invalid_q),
    .status_o     (status_o),
    .alarm_o      (alarm_o)
  );

endmodule

`default_nettype wire

// File: logic/lc_sync_cfg.sv
// Alarm mask and sticky invalid-encoding status for the sync block
// Software loads the mask, reads status and clears it with a strobe
`timescale 1ns/1ps
`default_nettype none

module lc_sync_cfg (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire                    cfg_mask_we_i,
  input  lc_sync_pkg::lc_flags_t cfg_mask_i,
  input  wire                    status_clr_i,
  input  lc_sync_pkg::lc_flags_t invalid_i,
  output lc_sync_pkg::lc_flags_t status_o,
  output logic                   alarm_o
);

  // Flat views, one bit per enable
  logic [lc_sync_pkg::NumSig-1:0] mask_q;
  logic [lc_sync_pkg::NumSig-1:0] status_q;
  logic [lc_sync_pkg::NumSig-1:0] status_d;
  logic [lc_sync_pkg::NumSig-1:0] invalid;

  assign invalid = invalid_i;

  ////////////////////////////////////////////////////////////
  // Mask register
  ////////////////////////////////////////////////////////////

  // All alarms enabled out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '1;
    end else if (cfg_mask_we_i) begin
      mask_q <= cfg_mask_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sticky status
  ////////////////////////////////////////////////////////////

  // Clear first, then set, so a new flag survives a clear
  assign status_d = (status_q & {lc_sync_pkg::NumSig{!status_clr_i}}) | invalid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  assign status_o = lc_sync_pkg::lc_flags_t'(status_q);

  // Combinational from status, masked bits never raise it
  assign alarm_o = |(status_q & mask_q);

endmodule

`default_nettype wire

// File: logic/lc_tx_monitor.sv
// Encoding checker for the synchronized life cycle enables
// Flags every field that is neither On nor Off, one cycle later
`timescale 1ns/1ps
`default_nettype none

module lc_tx_monitor (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  lc_sync_pkg::lc_bundle_t sync_bundle_i,
  output lc_sync_pkg::lc_flags_t  invalid_o
);

  ////////////////////////////////////////////////////////////
  // Encoding check
  ////////////////////////////////////////////////////////////

  // True for any pattern outside the two legal encodings
  function automatic logic is_invalid(lc_sync_pkg::lc_tx_t val);
    logic legal;
    legal = (val == lc_sync_pkg::On) || (val == lc_sync_pkg::Off);
    return !legal;
  endfunction

  // Raw per-field result for this cycle
  lc_sync_pkg::lc_flags_t invalid_d;

  // Registered flags, handed to the config block
  lc_sync_pkg::lc_flags_t invalid_q;

  always_comb begin
    invalid_d             = '0;
    // Test mode enable
    invalid_d.dft_en      = is_invalid(sync_bundle_i.dft_en);
    // Debug port enable
    invalid_d.hw_debug_en = is_invalid(sync_bundle_i.hw_debug_en);
    // Escalation enable
    invalid_d.escalate_en = is_invalid(sync_bundle_i.escalate_en);
  end

  ////////////////////////////////////////////////////////////
  // Flag register
  ////////////////////////////////////////////////////////////

  // One cycle behind the synchronized bundle
  // Pulses for as long as the bad value stays on the input
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      invalid_q <= '0;
    end else begin
      invalid_q <= invalid_d;
    end
  end

  assign invalid_o = invalid_q;

endmodule

`default_nettype wire

// File: logic/lc_sync.sv
// Synchronizes one life cycle enable and fans it out to separate consumers
// Instantiated once per enable by lc_sync_top
`timescale 1ns/1ps
`default_nettype none

module lc_sync #(
  // Number of separately driven output copies
  parameter int NumCopies = 2,
  // Set to 0 only when sender and receiver share a clock
  parameter bit AsyncOn = 1,
  // 0 resets to Off, 1 resets to On
  parameter bit ResetValueIsOn = 0
) (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  lc_sync_pkg::lc_tx_t                 lc_en_i,
  output lc_sync_pkg::lc_tx_t [NumCopies-1:0] lc_en_o
);

  ////////////////////////////////////////////////////////////
  // Reset value selection
  ////////////////////////////////////////////////////////////

  // Escalation style signals reset to On so the logic fails safe
  localparam lc_sync_pkg::lc_tx_t LcResetValue =
    ResetValueIsOn ? lc_sync_pkg::On : lc_sync_pkg::Off;

  // Single synchronized value before fan-out
  lc_sync_pkg::lc_tx_t lc_en;

  ////////////////////////////////////////////////////////////
  // Synchronizer or pass-through
  ////////////////////////////////////////////////////////////

  if (AsyncOn) begin : gen_flops
    // Two cycles of latency across the clock boundary
    lc_flop_2sync #(
      .ResetValue(LcResetValue)
    ) u_lc_flop_2sync (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .d_i    (lc_en_i),
      .q_o    (lc_en)
    );
  end else begin : gen_no_flops
    // Same clock domain, copies follow the input directly
    assign lc_en = lc_en_i;
  end

  ////////////////////////////////////////////////////////////
  // Output copies
  ////////////////////////////////////////////////////////////

  // Each consumer gets its own kept net
  // Keeps synthesis from collapsing the copies into one driver
  for (genvar j = 0; j < NumCopies; j++) begin : gen_copies
    (* keep *) lc_sync_pkg::lc_tx_t lc_en_buf;

    assign lc_en_buf  = lc_en;
    assign lc_en_o[j] = lc_en_buf;
  end

endmodule

`default_nettype wire

// File: logic/lc_flop_2sync.sv
// Two-flop synchronizer for a single life cycle enable
// Used by lc_sync as the metastability boundary of one signal
`timescale 1ns/1ps
`default_nettype none

module lc_flop_2sync #(
  // Value both stages take while in reset
  parameter lc_sync_pkg::lc_tx_t ResetValue = lc_sync_pkg::Off
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  lc_sync_pkg::lc_tx_t d_i,
  output lc_sync_pkg::lc_tx_t q_o
);

  // First stage may go metastable, second stage settles it
  lc_sync_pkg::lc_tx_t sync_q1;
  lc_sync_pkg::lc_tx_t sync_q2;

  // Value sampled at edge n is on q_o after edge n+1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q1 <= ResetValue;
      sync_q2 <= ResetValue;
    end else begin
      sync_q1 <= d_i;
      sync_q2 <= sync_q1;
    end
  end

  assign q_o = sync_q2;

endmodule

`default_nettype wire

// File: logic/lc_sync_pkg.sv
// Life cycle enable encodings and the signal bundles shared by the sync block
// All RTL files reference these by scoped names
`default_nettype none

package lc_sync_pkg;

  ////////////////////////////////////////////////////////////
  // Enable encoding
  ////////////////////////////////////////////////////////////

  // Width of one multi-bit life cycle enable
  parameter int TxWidth = 4;

  // Only On and Off are legal, anything else counts as Off
  typedef enum logic [TxWidth-1:0] {
    On  = 4'b0101,
    Off = 4'b1010
  } lc_tx_t;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Number of enables carried in one bundle
  parameter int NumSig = 3;

  // The three enables as they cross into this clock domain
  typedef struct packed {
    lc_tx_t dft_en;
    lc_tx_t hw_debug_en;
    lc_tx_t escalate_en;
  } lc_bundle_t;

  // One bit per enable, for mask, status and invalid pulses
  typedef struct packed {
    logic dft_en;
    logic hw_debug_en;
    logic escalate_en;
  } lc_flags_t;

endpackage

`default_nettype wire
